/* rtl/ccx_mon_config.svh */
`ifndef CCX_MON_CONFIG_SVH
`define CCX_MON_CONFIG_SVH

// Field widths of the crossbar packets as seen by the monitor
`define CCX_RQ_W    5
`define CCX_RT_W    4
`define CCX_THR_N   4
`define CCX_TID_W   2
`define CCX_CNT_W   16
`define CCX_KIND_W  4
`define CCX_ADDR_W  40
`define CCX_PAY_W   64
`define CCX_VEC_W   6

// PCX request type codes
`define CCX_RQ_LOAD     5'b00000
`define CCX_RQ_IMISS    5'b10000
`define CCX_RQ_STORE    5'b00001
`define CCX_RQ_CAS1     5'b00010
`define CCX_RQ_CAS2     5'b00011
`define CCX_RQ_STRLOAD  5'b00100
`define CCX_RQ_STRST    5'b00101
`define CCX_RQ_SWAP     5'b00110
`define CCX_RQ_STQ      5'b00111
`define CCX_RQ_INT      5'b01001
`define CCX_RQ_FPOP1    5'b01010
`define CCX_RQ_FPOP2    5'b01011
`define CCX_RQ_FWD_RQ   5'b01101
`define CCX_RQ_FWD_RPY  5'b01110
`define CCX_RQ_RSVD     5'b11111

// CPX return type codes
`define CCX_RT_LOAD       4'b0000
`define CCX_RT_IFILL      4'b0001
`define CCX_RT_INV        4'b0011
`define CCX_RT_ST_ACK     4'b0100
`define CCX_RT_AT_ACK     4'b0101
`define CCX_RT_INT        4'b0111
`define CCX_RT_TEST       4'b0110
`define CCX_RT_FP         4'b1000
`define CCX_RT_EVICT      4'b0010
`define CCX_RT_ERR        4'b1100
`define CCX_RT_STRLOAD    4'b1101
`define CCX_RT_STRST_ACK  4'b1110
`define CCX_RT_FWD_RQ     4'b1010
`define CCX_RT_FWD_RPY    4'b1011
`define CCX_RT_RSVD       4'b1111

`endif

/* rtl/ccx_mon_pkg.sv */
`default_nettype none

`include "ccx_mon_config.svh"

package ccx_mon_pkg;

   // Processor-to-cache request as it appears on the PCX bus
   typedef struct packed {
      logic                   vld;
      logic [`CCX_RQ_W-1:0]   rqtype;
      logic [`CCX_TID_W-1:0]  thr;
      logic [`CCX_ADDR_W-1:0] addr;
   } pcx_pkt_t;

   // Interrupt returns reuse the top of the payload word for the
   // interrupt type, the target thread and the vector
   typedef struct packed {
      logic [1:0]                                       int_type;
      logic [`CCX_TID_W-1:0]                            thr;
      logic [`CCX_VEC_W-1:0]                            vector;
      logic [`CCX_PAY_W-2-`CCX_TID_W-`CCX_VEC_W-1:0]    pad;
   } cpx_int_view_t;

   // The same 64 bits read either as raw return data or as an interrupt
   typedef union packed {
      logic [`CCX_PAY_W-1:0] data;
      cpx_int_view_t         intr;
   } cpx_payload_u;

   // Cache-to-processor return on the CPX bus
   typedef struct packed {
      logic                 vld;
      logic [`CCX_RT_W-1:0] rtntype;
      cpx_payload_u         payload;
   } cpx_pkt_t;

   // Decoded request kinds, the value doubles as the counter index
   typedef enum logic [`CCX_KIND_W-1:0] {
      PCX_LOAD, PCX_IMISS, PCX_STORE, PCX_CAS1,
      PCX_CAS2, PCX_SWAP, PCX_STRLOAD, PCX_STRST,
      PCX_STQ, PCX_INT, PCX_FWD_RQ, PCX_FWD_RPY,
      PCX_FPOP1, PCX_FPOP2, PCX_RSVD, PCX_UNKNOWN
   } pcx_kind_e;

   // Decoded return kinds, numbered the same way
   typedef enum logic [`CCX_KIND_W-1:0] {
      CPX_LOAD, CPX_IFILL, CPX_INV, CPX_ST_ACK,
      CPX_AT_ACK, CPX_INT, CPX_TEST, CPX_FP,
      CPX_EVICT, CPX_ERR, CPX_STRLOAD, CPX_STRST_ACK,
      CPX_FWD_RQ, CPX_FWD_RPY, CPX_RSVD, CPX_UNKNOWN
   } cpx_kind_e;

   typedef struct packed {
      logic                  vld;
      pcx_kind_e             kind;
      logic [`CCX_TID_W-1:0] thr;
   } pcx_evt_t;

   // Interrupt fields are only meaningful while is_int is set
   typedef struct packed {
      logic                  vld;
      cpx_kind_e             kind;
      logic                  is_int;
      logic [1:0]            int_type;
      logic [`CCX_TID_W-1:0] thr;
      logic [`CCX_VEC_W-1:0] vector;
   } cpx_evt_t;

   // Counter select, dir 0 picks the PCX bank and dir 1 the CPX bank
   typedef struct packed {
      logic                   dir;
      logic [`CCX_KIND_W-1:0] kind;
   } cnt_sel_t;

endpackage

`default_nettype wire

/* rtl/pcx_req_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ccx_mon_config.svh"

module pcx_req_decode (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable,
   input  logic                  req,
   input  ccx_mon_pkg::pcx_pkt_t pkt,
   output ccx_mon_pkg::pcx_evt_t evt
);

   logic                   req_q;
   logic                   qual;
   ccx_mon_pkg::pcx_kind_e kind_c;
   logic                   vld_q;
   ccx_mon_pkg::pcx_kind_e kind_q;
   logic [`CCX_TID_W-1:0]  thr_q;

   // The core raises its strobe one cycle ahead of the packet
   always_ff @(posedge clk) begin
      if (rst) begin
         req_q <= 1'b0;
      end else begin
         req_q <= req;
      end
   end

   // A vld with no strobe in the cycle before is stray bus activity
   assign qual = req_q & pkt.vld & enable;

   always_comb begin
      case (pkt.rqtype)
         `CCX_RQ_LOAD:    kind_c = ccx_mon_pkg::PCX_LOAD;
         `CCX_RQ_IMISS:   kind_c = ccx_mon_pkg::PCX_IMISS;
         `CCX_RQ_STORE:   kind_c = ccx_mon_pkg::PCX_STORE;
         `CCX_RQ_CAS1:    kind_c = ccx_mon_pkg::PCX_CAS1;
         `CCX_RQ_CAS2:    kind_c = ccx_mon_pkg::PCX_CAS2;
         `CCX_RQ_SWAP:    kind_c = ccx_mon_pkg::PCX_SWAP;
         `CCX_RQ_STRLOAD: kind_c = ccx_mon_pkg::PCX_STRLOAD;
         `CCX_RQ_STRST:   kind_c = ccx_mon_pkg::PCX_STRST;
         `CCX_RQ_STQ:     kind_c = ccx_mon_pkg::PCX_STQ;
         `CCX_RQ_INT:     kind_c = ccx_mon_pkg::PCX_INT;
         `CCX_RQ_FWD_RQ:  kind_c = ccx_mon_pkg::PCX_FWD_RQ;
         `CCX_RQ_FWD_RPY: kind_c = ccx_mon_pkg::PCX_FWD_RPY;
         `CCX_RQ_FPOP1:   kind_c = ccx_mon_pkg::PCX_FPOP1;
         `CCX_RQ_FPOP2:   kind_c = ccx_mon_pkg::PCX_FPOP2;
         `CCX_RQ_RSVD:    kind_c = ccx_mon_pkg::PCX_RSVD;
         default:         kind_c = ccx_mon_pkg::PCX_UNKNOWN;
      endcase
   end

   // One event strobe per qualified packet
   always_ff @(posedge clk) begin
      if (rst) begin
         vld_q <= 1'b0;
      end else begin
         vld_q <= qual;
      end
   end

   // Kind and thread only move when a packet is taken
   always_ff @(posedge clk) begin
      if (qual) begin
         kind_q <= kind_c;
         thr_q  <= pkt.thr;
      end
   end

   assign evt = '{vld: vld_q, kind: kind_q, thr: thr_q};

   // Every strobe is followed by a packet that names one of the core's threads
   a_req_pkt: assert property (@(posedge clk) disable iff (rst)
      req_q |-> (pkt.vld && int'(pkt.thr) < `CCX_THR_N));

endmodule

`default_nettype wire

/* rtl/cpx_ret_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ccx_mon_config.svh"

module cpx_ret_decode (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable,
   input  ccx_mon_pkg::cpx_pkt_t pkt,
   output ccx_mon_pkg::cpx_evt_t evt
);

   logic                   qual;
   ccx_mon_pkg::cpx_kind_e kind_c;
   logic                   is_int_c;
   logic [1:0]             int_type_c;
   logic [`CCX_TID_W-1:0]  thr_c;
   logic [`CCX_VEC_W-1:0]  vector_c;
   logic                   vld_q;
   logic                   is_int_q;
   ccx_mon_pkg::cpx_kind_e kind_q;
   logic [1:0]             int_type_q;
   logic [`CCX_TID_W-1:0]  thr_q;
   logic [`CCX_VEC_W-1:0]  vector_q;

   // Returns need no strobe, vld alone marks a packet
   assign qual = pkt.vld & enable;

   always_comb begin
      case (pkt.rtntype)
         `CCX_RT_LOAD:      kind_c = ccx_mon_pkg::CPX_LOAD;
         `CCX_RT_IFILL:     kind_c = ccx_mon_pkg::CPX_IFILL;
         `CCX_RT_INV:       kind_c = ccx_mon_pkg::CPX_INV;
         `CCX_RT_ST_ACK:    kind_c = ccx_mon_pkg::CPX_ST_ACK;
         `CCX_RT_AT_ACK:    kind_c = ccx_mon_pkg::CPX_AT_ACK;
         `CCX_RT_INT:       kind_c = ccx_mon_pkg::CPX_INT;
         `CCX_RT_TEST:      kind_c = ccx_mon_pkg::CPX_TEST;
         `CCX_RT_FP:        kind_c = ccx_mon_pkg::CPX_FP;
         `CCX_RT_EVICT:     kind_c = ccx_mon_pkg::CPX_EVICT;
         `CCX_RT_ERR:       kind_c = ccx_mon_pkg::CPX_ERR;
         `CCX_RT_STRLOAD:   kind_c = ccx_mon_pkg::CPX_STRLOAD;
         `CCX_RT_STRST_ACK: kind_c = ccx_mon_pkg::CPX_STRST_ACK;
         `CCX_RT_FWD_RQ:    kind_c = ccx_mon_pkg::CPX_FWD_RQ;
         `CCX_RT_FWD_RPY:   kind_c = ccx_mon_pkg::CPX_FWD_RPY;
         `CCX_RT_RSVD:      kind_c = ccx_mon_pkg::CPX_RSVD;
         default:           kind_c = ccx_mon_pkg::CPX_UNKNOWN;
      endcase
   end

   // Only an INT return carries the interrupt layout, any other kind keeps
   // raw data in the payload and must not leak into the interrupt fields
   always_comb begin
      is_int_c   = qual && (kind_c == ccx_mon_pkg::CPX_INT);
      int_type_c = '0;
      thr_c      = '0;
      vector_c   = '0;
      if (is_int_c) begin
         int_type_c = pkt.payload.intr.int_type;
         thr_c      = pkt.payload.intr.thr;
         vector_c   = pkt.payload.intr.vector;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         vld_q    <= 1'b0;
         is_int_q <= 1'b0;
      end else begin
         vld_q    <= qual;
         is_int_q <= is_int_c;
      end
   end

   // Payload side of the event, held between packets
   always_ff @(posedge clk) begin
      if (qual) begin
         kind_q     <= kind_c;
         int_type_q <= int_type_c;
         thr_q      <= thr_c;
         vector_q   <= vector_c;
      end
   end

   assign evt = '{vld: vld_q, kind: kind_q, is_int: is_int_q, int_type: int_type_q,
                  thr: thr_q, vector: vector_q};

   // The tracker trusts is_int, so it has to agree with the decoded kind
   a_int_kind: assert property (@(posedge clk) disable iff (rst)
      evt.is_int |-> (evt.vld && evt.kind == ccx_mon_pkg::CPX_INT));

endmodule

`default_nettype wire

/* rtl/thread_state_track.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ccx_mon_config.svh"

module thread_state_track (
   input  logic                  clk,
   input  logic                  rst,
   input  ccx_mon_pkg::cpx_evt_t evt,
   output logic [`CCX_THR_N-1:0] active_mask,
   output logic [`CCX_THR_N-1:0] back_mask
);

   logic [`CCX_THR_N-1:0] active_q;
   logic [`CCX_THR_N-1:0] back_q;
   logic [`CCX_THR_N-1:0] thr_bit;
   logic                  wake;
   logic                  resume;
   logic                  was_active;

   // One-hot select of the thread named in the interrupt
   assign thr_bit = {{(`CCX_THR_N-1){1'b0}}, 1'b1} << evt.thr;

   // int_type 1 is a wake-up and int_type 3 a resume
   assign wake   = evt.vld && evt.is_int && (evt.int_type == 2'd1);
   assign resume = evt.vld && evt.is_int && (evt.int_type == 2'd3);

   // Sampled before this event touches the mask
   assign was_active = |(active_q & thr_bit);

   always_ff @(posedge clk) begin
      if (rst) begin
         active_q <= '0;
         back_q   <= '0;
      end else begin
         // A second wake-up, or a resume, of a running thread means it came back
         if ((wake || resume) && was_active) begin
            back_q <= back_q | thr_bit;
         end
         // Every wake-up leaves the thread running
         if (wake) begin
            active_q <= active_q | thr_bit;
         end
      end
   end

   assign active_mask = active_q;
   assign back_mask   = back_q;

   // A thread can only be back once it has been active
   a_back_subset: assert property (@(posedge clk) disable iff (rst)
      (back_mask & ~active_mask) == '0);

endmodule

`default_nettype wire

/* rtl/ccx_type_counters.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ccx_mon_config.svh"

module ccx_type_counters (
   input  logic                  clk,
   input  logic                  rst,
   input  ccx_mon_pkg::pcx_evt_t pcx_evt,
   input  ccx_mon_pkg::cpx_evt_t cpx_evt,
   input  logic                  rd,
   input  ccx_mon_pkg::cnt_sel_t sel,
   output logic                  ack,
   output logic [`CCX_CNT_W-1:0] data
);

   // Bank 0 counts PCX kinds and bank 1 counts CPX kinds, same as sel.dir
   localparam int BANK_N = 2;
   localparam int KIND_N = 1 << `CCX_KIND_W;

   logic [`CCX_CNT_W-1:0]  cnt [BANK_N][KIND_N];
   logic [BANK_N-1:0]      inc_vld;
   logic [`CCX_KIND_W-1:0] inc_kind [BANK_N];
   logic                   ack_q;
   logic [`CCX_CNT_W-1:0]  data_q;

   // Both directions feed the banks through one indexed path
   assign inc_vld[0]  = pcx_evt.vld;
   assign inc_kind[0] = pcx_evt.kind;
   assign inc_vld[1]  = cpx_evt.vld;
   assign inc_kind[1] = cpx_evt.kind;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < BANK_N; b++) begin
            for (int k = 0; k < KIND_N; k++) begin
               cnt[b][k] <= '0;
            end
         end
      end else begin
         // Each bank advances on its own strobe, both may fire together
         for (int b = 0; b < BANK_N; b++) begin
            if (inc_vld[b] && (cnt[b][inc_kind[b]] != '1)) begin
               cnt[b][inc_kind[b]] <= cnt[b][inc_kind[b]] + 1'b1;
            end
         end
      end
   end

   // Acknowledge follows the read strobe by one cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= rd;
      end
   end

   // Capture the selected counter as it stands during the read cycle
   always_ff @(posedge clk) begin
      if (rd) begin
         data_q <= cnt[sel.dir][sel.kind];
      end
   end

   assign ack  = ack_q;
   assign data = data_q;

endmodule

`default_nettype wire

/* rtl/ccx_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ccx_mon_config.svh"

module ccx_monitor (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable,
   input  logic                  pcx_req,
   input  ccx_mon_pkg::pcx_pkt_t pcx_pkt,
   input  ccx_mon_pkg::cpx_pkt_t cpx_pkt,
   input  logic                  cnt_rd,
   input  ccx_mon_pkg::cnt_sel_t cnt_sel,
   output ccx_mon_pkg::pcx_evt_t pcx_evt,
   output ccx_mon_pkg::cpx_evt_t cpx_evt,
   output logic [`CCX_THR_N-1:0] active_mask,
   output logic [`CCX_THR_N-1:0] back_mask,
   output logic                  cnt_ack,
   output logic [`CCX_CNT_W-1:0] cnt_data
);

   // Request side, strobe-qualified and decoded one cycle after the packet
   pcx_req_decode u_pcx_dec (
      .clk    (clk),
      .rst    (rst),
      .enable (enable),
      .req    (pcx_req),
      .pkt    (pcx_pkt),
      .evt    (pcx_evt)
   );

   // Return side, also the source of interrupt events
   cpx_ret_decode u_cpx_dec (
      .clk    (clk),
      .rst    (rst),
      .enable (enable),
      .pkt    (cpx_pkt),
      .evt    (cpx_evt)
   );

   thread_state_track u_thr (
      .clk         (clk),
      .rst         (rst),
      .evt         (cpx_evt),
      .active_mask (active_mask),
      .back_mask   (back_mask)
   );

   // Counters see the same events that leave the top level
   ccx_type_counters u_cnt (
      .clk     (clk),
      .rst     (rst),
      .pcx_evt (pcx_evt),
      .cpx_evt (cpx_evt),
      .rd      (cnt_rd),
      .sel     (cnt_sel),
      .ack     (cnt_ack),
      .data    (cnt_data)
   );

endmodule

`default_nettype wire

/* sim/ccx_monitor_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ccx_mon_config.svh"

module ccx_monitor_tb;

   // Events and acks arrive within two cycles, so this much silence means a hang
   localparam int WAIT_MAX = 20;
   // Cycles watched for a packet that must not produce an event
   localparam int QUIET_N  = 4;

   logic                  clk;
   logic                  rst;
   logic                  enable;
   logic                  pcx_req;
   ccx_mon_pkg::pcx_pkt_t pcx_pkt;
   ccx_mon_pkg::cpx_pkt_t cpx_pkt;
   logic                  cnt_rd;
   ccx_mon_pkg::cnt_sel_t cnt_sel;
   ccx_mon_pkg::pcx_evt_t pcx_evt;
   ccx_mon_pkg::cpx_evt_t cpx_evt;
   logic [`CCX_THR_N-1:0] active_mask;
   logic [`CCX_THR_N-1:0] back_mask;
   logic                  cnt_ack;
   logic [`CCX_CNT_W-1:0] cnt_data;

   int unsigned rand_state;
   int          err_count;
   int          test_count;
   int          fail_count;
   logic        aborted;
   // Kind of the most recent event from either direction
   logic [3:0]  last_kind;

   ccx_monitor uut (
      .clk         (clk),
      .rst         (rst),
      .enable      (enable),
      .pcx_req     (pcx_req),
      .pcx_pkt     (pcx_pkt),
      .cpx_pkt     (cpx_pkt),
      .cnt_rd      (cnt_rd),
      .cnt_sel     (cnt_sel),
      .pcx_evt     (pcx_evt),
      .cpx_evt     (cpx_evt),
      .active_mask (active_mask),
      .back_mask   (back_mask),
      .cnt_ack     (cnt_ack),
      .cnt_data    (cnt_data)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   // LCG for the filler fields, addresses and pad bits the DUT never decodes
   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
         err_count++;
      end
   endtask

   // Polls mid-cycle, where registered outputs have settled
   // which selects 0 for the PCX event, 1 for the CPX event and 2 for the ack
   task automatic wait_strobe(input int which, output logic seen);
      int n;
      seen = 1'b0;
      n = 0;
      while (!seen && n < WAIT_MAX) begin
         @(negedge clk);
         case (which)
            0:       seen = pcx_evt.vld;
            1:       seen = cpx_evt.vld;
            default: seen = cnt_ack;
         endcase
         n++;
      end
   endtask

   // The packet was not qualified, so the event strobe must stay low
   task automatic expect_quiet(input int which);
      int   n;
      logic hit;
      hit = 1'b0;
      for (n = 0; n < QUIET_N; n++) begin
         @(negedge clk);
         hit = hit | ((which == 0) ? pcx_evt.vld : cpx_evt.vld);
      end
      if (hit) begin
         $display("An event appeared at %0t ns for a packet that should be ignored", $time);
         err_count++;
      end
   endtask

   task automatic send_pcx(input logic [4:0] code, input logic [1:0] thr,
                           input logic strobe);
      logic [31:0] hi;
      logic [31:0] lo;
      logic        seen;
      hi = next_rand();
      lo = next_rand();
      // Strobe one cycle, packet the next
      if (strobe) begin
         @(posedge clk);
         pcx_req <= 1'b1;
      end
      @(posedge clk);
      pcx_req        <= 1'b0;
      pcx_pkt.vld    <= 1'b1;
      pcx_pkt.rqtype <= code;
      pcx_pkt.thr    <= thr;
      pcx_pkt.addr   <= {hi[7:0], lo};
      @(posedge clk);
      pcx_pkt.vld <= 1'b0;
      if (strobe && enable) begin
         wait_strobe(0, seen);
         if (seen) begin
            check_value(64'(pcx_evt.thr), 64'(thr), "PCX event thread");
            last_kind = pcx_evt.kind;
         end else begin
            $display("Timed out waiting for the PCX event of request type %b", code);
            err_count++;
            aborted = 1'b1;
         end
      end else begin
         expect_quiet(0);
      end
   endtask

   task automatic send_cpx(input logic [3:0] code, input logic [1:0] int_type,
                           input logic [1:0] thr, input logic [5:0] vec);
      ccx_mon_pkg::cpx_payload_u pay;
      logic [31:0]               hi;
      logic [31:0]               lo;
      logic                      is_int;
      logic                      seen;
      hi = next_rand();
      lo = next_rand();
      // Payload is always laid out like an interrupt, only INT returns may use it
      pay.intr.int_type = int_type;
      pay.intr.thr      = thr;
      pay.intr.vector   = vec;
      pay.intr.pad      = {hi[21:0], lo};
      is_int = (code == `CCX_RT_INT);
      @(posedge clk);
      cpx_pkt.vld     <= 1'b1;
      cpx_pkt.rtntype <= code;
      cpx_pkt.payload <= pay;
      @(posedge clk);
      cpx_pkt.vld <= 1'b0;
      if (enable) begin
         wait_strobe(1, seen);
         if (seen) begin
            check_value(64'(cpx_evt.is_int), 64'(is_int), "CPX is_int");
            check_value(64'(cpx_evt.int_type), is_int ? 64'(int_type) : 64'd0, "CPX int_type");
            check_value(64'(cpx_evt.thr), is_int ? 64'(thr) : 64'd0, "CPX thread");
            check_value(64'(cpx_evt.vector), is_int ? 64'(vec) : 64'd0, "CPX vector");
            last_kind = cpx_evt.kind;
         end else begin
            $display("Timed out waiting for the CPX event of return type %b", code);
            err_count++;
            aborted = 1'b1;
         end
      end else begin
         expect_quiet(1);
      end
   endtask

   task automatic read_counter(input logic dir, input logic [3:0] kind,
                               input logic [15:0] exp);
      logic seen;
      @(posedge clk);
      cnt_rd       <= 1'b1;
      cnt_sel.dir  <= dir;
      cnt_sel.kind <= kind;
      @(posedge clk);
      cnt_rd <= 1'b0;
      wait_strobe(2, seen);
      if (seen) begin
         check_value(64'(cnt_data), 64'(exp), $sformatf("counter dir %0d kind %0d", dir, kind));
      end else begin
         $display("Timed out waiting for the ack of a counter read");
         err_count++;
         aborted = 1'b1;
      end
   endtask

   // Masks move one cycle after the interrupt event, so let two edges pass
   task automatic check_masks(input logic [3:0] act, input logic [3:0] back);
      @(negedge clk);
      @(negedge clk);
      check_value(64'(active_mask), 64'(act), "active mask");
      check_value(64'(back_mask), 64'(back), "back mask");
   endtask

   initial begin
      int         fd;
      int         rc;
      int         ch;
      int         a;
      int         b;
      int         c;
      int         d;
      int         errs_before;
      logic [7:0] cmd;
      rst        = 1'b1;
      enable     = 1'b0;
      pcx_req    = 1'b0;
      pcx_pkt    = '0;
      cpx_pkt    = '0;
      cnt_rd     = 1'b0;
      cnt_sel    = '0;
      rand_state = 60369;
      err_count  = 0;
      test_count = 0;
      fail_count = 0;
      aborted    = 1'b0;
      last_kind  = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // Everything starts from zero after reset
      errs_before = err_count;
      check_masks(4'b0000, 4'b0000);
      for (int k = 0; k < 32 && !aborted; k++) begin
         read_counter(k[4], k[3:0], 16'd0);
      end
      test_count++;
      if (err_count != errs_before) begin
         fail_count++;
      end
      $display("test %0d reset: %s", test_count, (err_count == errs_before) ? "ok" : "error");

      fd = $fopen("sim/ccx_monitor_tests.txt", "r");
      if (fd == 0) begin
         $display("Could not open the test file sim/ccx_monitor_tests.txt");
         err_count++;
         aborted = 1'b1;
      end
      while (!aborted) begin
         rc = $fscanf(fd, " %c", cmd);
         if (rc != 1) begin
            break;
         end
         if (cmd == "#") begin
            ch = $fgetc(fd);
            while (ch != 10 && ch != -1) begin
               ch = $fgetc(fd);
            end
            continue;
         end
         errs_before = err_count;
         case (cmd)
            "P": begin
               rc = $fscanf(fd, "%b %d", a, b);
               send_pcx(5'(a), 2'(b), 1'b1);
            end
            "Q": begin
               rc = $fscanf(fd, "%b", a);
               send_pcx(5'(a), 2'd0, 1'b0);
            end
            "C": begin
               rc = $fscanf(fd, "%b %d %d %d", a, b, c, d);
               send_cpx(4'(a), 2'(b), 2'(c), 6'(d));
            end
            "E": begin
               rc = $fscanf(fd, "%d", a);
               @(posedge clk);
               enable <= a[0];
            end
            "R": begin
               rc = $fscanf(fd, "%d %d %d", a, b, c);
               read_counter(a[0], 4'(b), 16'(c));
            end
            "M": begin
               rc = $fscanf(fd, "%b %b", a, b);
               check_masks(4'(a), 4'(b));
            end
            "K": begin
               rc = $fscanf(fd, "%d", a);
               check_value(64'(last_kind), 64'(a), "last event kind");
            end
            default: begin
               $display("Unknown command %c in the test file", cmd);
               err_count++;
               aborted = 1'b1;
            end
         endcase
         test_count++;
         if (err_count != errs_before) begin
            fail_count++;
         end
         $display("test %0d %c: %s", test_count, cmd, (err_count == errs_before) ? "ok" : "error");
      end
      if (fd != 0) begin
         $fclose(fd);
      end

      $display("summary: %0d tests, %0d failed, %0d errors", test_count, fail_count, err_count);
      if (err_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim/ccx_monitor_tests.txt */
# P rqtype(bin) thr | Q rqtype(bin) | C rtntype(bin) int_type thr vector | E enable
# R dir kind count | M active(bin) back(bin) | K kind of last event
E 1
P 00000 1
K 0
P 10000 3
K 1
P 00111 0
K 8
P 01110 2
K 11
P 10101 1
K 15
P 00000 2
Q 00000
K 0
E 0
P 00000 1
C 0000 0 0 0
E 1
C 0000 0 0 0
K 0
C 0001 0 0 0
K 1
C 1011 0 0 0
K 13
C 1001 0 0 0
K 15
R 0 0 2
R 0 1 1
R 0 8 1
R 0 11 1
R 0 15 1
R 1 0 1
R 1 13 1
R 1 15 1
C 0111 1 2 17
K 5
M 0100 0000
C 0111 1 2 17
M 0100 0100
C 0111 3 1 3
M 0100 0100
C 0111 0 0 9
C 0111 2 3 9
M 0100 0100
C 0001 1 1 4
M 0100 0100
C 0111 1 0 1
M 0101 0100
C 0111 3 0 2
M 0101 0101
R 1 5 7
R 1 1 2

/* ccx_monitor.f */
+incdir+rtl
rtl/ccx_mon_pkg.sv
rtl/pcx_req_decode.sv
rtl/cpx_ret_decode.sv
rtl/thread_state_track.sv
rtl/ccx_type_counters.sv
rtl/ccx_monitor.sv
sim/ccx_monitor_tb.sv

/* Makefile */
TOP := ccx_monitor_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f ccx_monitor.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir
